//--- compile.f
+incdir+common
common/fabric_pkg.sv
common/ocp_if.sv
fabric/fabric_port_demux.sv
fabric/fabric_port.sv
fabric/fabric_resp_join.sv
source/ocp_fabric.sv
testbench/tb_clock_gen.sv
testbench/tb_ocp_fabric.sv

//--- Bender.yml
package:
  name: ocp_fabric

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fabric_pkg.sv
      - common/ocp_if.sv
      - fabric/fabric_port_demux.sv
      - fabric/fabric_port.sv
      - fabric/fabric_resp_join.sv
      - source/ocp_fabric.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_ocp_fabric.sv

//--- testbench/tb_ocp_fabric.sv
`include "fabric_consts.svh"

module tb_ocp_fabric;

localparam int NUM_ROWS = 14;
localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + 16;	// Rows plus the reset time
localparam int MEM_WORDS = 256;	// Byte addresses below 0x400 per port

logic	clk;
logic	nrst;

// Master side of the DUT
fabric_pkg::addr_t	ibus_addr, dbus_addr;
fabric_pkg::cmd_t	ibus_cmd, dbus_cmd;
fabric_pkg::data_t	ibus_data, dbus_data, ibus_rdata, dbus_rdata;
fabric_pkg::ben_t	ibus_ben, dbus_ben;
logic			ibus_accept, dbus_accept;
fabric_pkg::resp_t	ibus_resp, dbus_resp;

// Slave ports, gathered into arrays for the memory models
fabric_pkg::addr_t	p_addr [2];
fabric_pkg::cmd_t	p_cmd [2];
fabric_pkg::data_t	p_data [2];
fabric_pkg::ben_t	p_ben [2];
logic			s_acc [2] = '{default: 1'b0};
fabric_pkg::data_t	s_data [2] = '{default: '0};
fabric_pkg::resp_t	s_resp [2] = '{default: `OCP_RESP_NULL};

// Stimulus table with the expected read data of each side
fabric_pkg::cmd_t	tab_icmd [NUM_ROWS], tab_dcmd [NUM_ROWS];
fabric_pkg::addr_t	tab_iaddr [NUM_ROWS], tab_daddr [NUM_ROWS];
fabric_pkg::data_t	tab_idata [NUM_ROWS], tab_ddata [NUM_ROWS];
fabric_pkg::ben_t	tab_iben [NUM_ROWS], tab_dben [NUM_ROWS];
fabric_pkg::data_t	exp_idata [NUM_ROWS], exp_ddata [NUM_ROWS];

fabric_pkg::data_t	slave_mem [2][MEM_WORDS];	// Contents behind each port
fabric_pkg::data_t	ref_mem [2][MEM_WORDS];	// What the slaves should hold

// Command log of the slave models, the index is the running sequence number
int			log_cnt = 0;
int			log_port [64];
fabric_pkg::addr_t	log_addr [64];
fabric_pkg::cmd_t	log_cmd [64];

int			seed = 1;
int			cycles = 0;
int			phase [2];	// 0 idle, 1 stall, 2 accept, 3 response delay
int			cnt [2];
fabric_pkg::data_t	rdata [2];
logic			is_read [2];

tb_clock_gen u_clock_gen (
	.o_clk	(clk),
	.o_nrst	(nrst)
);

ocp_fabric u_ocp_fabric (
	.clk		(clk),
	.nrst		(nrst),
	.i_i_maddr	(ibus_addr),
	.i_i_mcmd	(ibus_cmd),
	.i_i_mdata	(ibus_data),
	.i_i_mbyteen	(ibus_ben),
	.o_i_scmdaccept	(ibus_accept),
	.o_i_sdata	(ibus_rdata),
	.o_i_sresp	(ibus_resp),
	.i_d_maddr	(dbus_addr),
	.i_d_mcmd	(dbus_cmd),
	.i_d_mdata	(dbus_data),
	.i_d_mbyteen	(dbus_ben),
	.o_d_scmdaccept	(dbus_accept),
	.o_d_sdata	(dbus_rdata),
	.o_d_sresp	(dbus_resp),
	.o_p0_maddr	(p_addr[0]),
	.o_p0_mcmd	(p_cmd[0]),
	.o_p0_mdata	(p_data[0]),
	.o_p0_mbyteen	(p_ben[0]),
	.i_p0_scmdaccept	(s_acc[0]),
	.i_p0_sdata	(s_data[0]),
	.i_p0_sresp	(s_resp[0]),
	.o_p1_maddr	(p_addr[1]),
	.o_p1_mcmd	(p_cmd[1]),
	.o_p1_mdata	(p_data[1]),
	.o_p1_mbyteen	(p_ben[1]),
	.i_p1_scmdaccept	(s_acc[1]),
	.i_p1_sdata	(s_data[1]),
	.i_p1_sresp	(s_resp[1])
);

// ***************************************************************************
// Routing rules and helpers
// ***************************************************************************

// Bit 31 clear means port 0, otherwise bits 30..20 plus one
function automatic int target_port(input fabric_pkg::addr_t addr);
	return addr[31] ? int'(addr[30:20]) + 1 : 0;
endfunction

function automatic fabric_pkg::addr_t slave_addr(input fabric_pkg::addr_t addr);
	return addr[31] ? {12'h000, addr[19:0]} : addr;	// Ports above 0 see 20 bits
endfunction

function automatic fabric_pkg::data_t merge_bytes(input fabric_pkg::data_t old_word,
	input fabric_pkg::data_t new_word, input fabric_pkg::ben_t ben);
	fabric_pkg::data_t res;
	res = old_word;
	for (int b = 0; b < 4; b++)
		if (ben[b])
			res[8*b +: 8] = new_word[8*b +: 8];
	return res;
endfunction

// Start contents depend on the port and the whole byte address
function automatic fabric_pkg::data_t fill_word(input int port, input int word);
	fabric_pkg::addr_t a;
	a = word * 4;
	return (a * 32'h0001_0101) ^ (port != 0 ? 32'hA5C3_0000 : 32'h3C5A_0000);
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected)
	begin
		$display("ERR time %0t %s actual %h expected %h", $time, name, actual, expected);
		$display("Simulation failed");
		$fatal(1, "mismatch on %s", name);
	end
endtask

task automatic set_row(input int r, input fabric_pkg::cmd_t icmd, input fabric_pkg::addr_t iaddr,
	input fabric_pkg::data_t idata, input fabric_pkg::ben_t iben, input fabric_pkg::cmd_t dcmd,
	input fabric_pkg::addr_t daddr, input fabric_pkg::data_t ddata, input fabric_pkg::ben_t dben);
	tab_icmd[r] = icmd;
	tab_iaddr[r] = iaddr;
	tab_idata[r] = idata;
	tab_iben[r] = iben;
	tab_dcmd[r] = dcmd;
	tab_daddr[r] = daddr;
	tab_ddata[r] = ddata;
	tab_dben[r] = dben;
endtask

// Applies one command to the reference memory and gives back the read word
task automatic ref_access(input fabric_pkg::cmd_t cmd, input fabric_pkg::addr_t addr,
	input fabric_pkg::data_t data, input fabric_pkg::ben_t ben, output fabric_pkg::data_t rd);
	int p;
	int w;
	p = target_port(addr);
	w = int'(slave_addr(addr) >> 2);
	rd = '0;
	if (cmd == `OCP_CMD_WRITE)
		ref_mem[p][w] = merge_bytes(ref_mem[p][w], data, ben);
	else if (cmd == `OCP_CMD_READ)
		rd = ref_mem[p][w];
endtask

// ***************************************************************************
// Slave memory models
// ***************************************************************************

always @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		for (int p = 0; p < 2; p++)
		begin
			phase[p] <= 0;
			cnt[p] <= 0;
			s_acc[p] <= 1'b0;
			s_data[p] <= '0;
			s_resp[p] <= `OCP_RESP_NULL;
		end
	end
	else
	begin
		for (int p = 0; p < 2; p++)
		begin
			s_resp[p] <= `OCP_RESP_NULL;	// DVA lasts a single cycle
			case (phase[p])
			0:
				if (p_cmd[p] != `OCP_CMD_IDLE)
				begin
					log_port[log_cnt] = p;
					log_addr[log_cnt] = p_addr[p];
					log_cmd[log_cnt] = p_cmd[p];
					log_cnt++;
					is_read[p] = (p_cmd[p] == `OCP_CMD_READ);
					if (p_cmd[p] == `OCP_CMD_WRITE)
						slave_mem[p][p_addr[p][9:2]] = merge_bytes(
							slave_mem[p][p_addr[p][9:2]], p_data[p], p_ben[p]);
					rdata[p] = slave_mem[p][p_addr[p][9:2]];
					cnt[p] <= {$random(seed)} % 3;	// Stall of 0 to 2 cycles
					phase[p] <= 1;
				end
			1:
				if (cnt[p] == 0)
				begin
					s_acc[p] <= 1'b1;
					phase[p] <= 2;
				end
				else
					cnt[p] <= cnt[p] - 1;
			2:
			begin
				s_acc[p] <= 1'b0;	// The port takes the command on this edge
				cnt[p] <= {$random(seed)} % 3;
				phase[p] <= 3;
			end
			default:
				if (cnt[p] == 0)
				begin
					s_resp[p] <= `OCP_RESP_DVA;	// Response 1 to 3 cycles after accept
					s_data[p] <= is_read[p] ? rdata[p] : '0;
					phase[p] <= 0;
				end
				else
					cnt[p] <= cnt[p] - 1;
			endcase
		end
	end
end

// Hard limit on the run length
always @(posedge clk)
begin
	cycles <= cycles + 1;
	if (cycles >= TIMEOUT_CYCLES)
	begin
		$display("Timeout: the fabric did not answer within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end
end

// ***************************************************************************
// Row execution
// ***************************************************************************

// Log entries of a row, D first on a shared port and in port order otherwise
task automatic check_log(input int r, input int base);
	int n;
	int e_port [2];
	fabric_pkg::addr_t e_addr [2];
	fabric_pkg::cmd_t e_cmd [2];
	logic i_first;
	n = 0;
	i_first = (tab_icmd[r] != `OCP_CMD_IDLE) && (tab_dcmd[r] != `OCP_CMD_IDLE) &&
		(target_port(tab_iaddr[r]) < target_port(tab_daddr[r]));
	for (int k = 0; k < 2; k++)
	begin
		if ((k == 0) == i_first && tab_icmd[r] != `OCP_CMD_IDLE)
		begin
			e_port[n] = target_port(tab_iaddr[r]);
			e_addr[n] = slave_addr(tab_iaddr[r]);
			e_cmd[n] = tab_icmd[r];
			n++;
		end
		else if ((k == 0) != i_first && tab_dcmd[r] != `OCP_CMD_IDLE)
		begin
			e_port[n] = target_port(tab_daddr[r]);
			e_addr[n] = slave_addr(tab_daddr[r]);
			e_cmd[n] = tab_dcmd[r];
			n++;
		end
	end
	check_value("log_count", log_cnt - base, n);
	for (int k = 0; k < n; k++)
	begin
		check_value("log_port", log_port[base + k], e_port[k]);
		check_value("log_addr", log_addr[base + k], e_addr[k]);
		check_value("log_cmd", log_cmd[base + k], e_cmd[k]);
	end
endtask

task automatic run_row(input int r);
	logic i_done;
	logic d_done;
	int base;
	base = log_cnt;
	i_done = (tab_icmd[r] == `OCP_CMD_IDLE);
	d_done = (tab_dcmd[r] == `OCP_CMD_IDLE);
	@(posedge clk);
	ibus_cmd <= tab_icmd[r];
	ibus_addr <= tab_iaddr[r];
	ibus_data <= tab_idata[r];
	ibus_ben <= tab_iben[r];
	dbus_cmd <= tab_dcmd[r];
	dbus_addr <= tab_daddr[r];
	dbus_data <= tab_ddata[r];
	dbus_ben <= tab_dben[r];
	@(negedge clk);
	check_value("o_i_scmdaccept", ibus_accept, 1'b1);	// Both FSMs are idle here
	check_value("o_d_scmdaccept", dbus_accept, 1'b1);
	@(posedge clk);
	ibus_cmd <= `OCP_CMD_IDLE;	// Taken on this edge
	dbus_cmd <= `OCP_CMD_IDLE;
	while (!(i_done && d_done))
	begin
		@(negedge clk);
		if (!i_done && ibus_resp == `OCP_RESP_DVA)
		begin
			if (tab_icmd[r] == `OCP_CMD_READ)
				check_value("o_i_sdata", ibus_rdata, exp_idata[r]);
			i_done = 1'b1;
		end
		if (!d_done && dbus_resp == `OCP_RESP_DVA)
		begin
			if (tab_dcmd[r] == `OCP_CMD_READ)
				check_value("o_d_sdata", dbus_rdata, exp_ddata[r]);
			d_done = 1'b1;
		end
	end
	check_log(r, base);
endtask

// ***************************************************************************
// Main sequence
// ***************************************************************************

initial
begin
	fabric_pkg::data_t rd;
	ibus_cmd = `OCP_CMD_IDLE;
	ibus_addr = '0;
	ibus_data = '0;
	ibus_ben = '0;
	dbus_cmd = `OCP_CMD_IDLE;
	dbus_addr = '0;
	dbus_data = '0;
	dbus_ben = '0;
	for (int p = 0; p < 2; p++)
		for (int w = 0; w < MEM_WORDS; w++)
		begin
			slave_mem[p][w] = fill_word(p, w);
			ref_mem[p][w] = fill_word(p, w);
		end

	// Reads on port 0, then partial writes on both ports and read back
	set_row(0, `OCP_CMD_READ, 32'h0000_0010, '0, 4'hF, `OCP_CMD_IDLE, '0, '0, '0);
	set_row(1, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_READ, 32'h0000_0020, '0, 4'hF);
	set_row(2, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_WRITE, 32'h0000_0020, 32'hDEAD_BEEF, 4'b0011);
	set_row(3, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_WRITE, 32'h8000_0104, 32'h1122_3344, 4'b1100);
	set_row(4, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_READ, 32'h0000_0020, '0, 4'hF);
	set_row(5, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_READ, 32'h8000_0104, '0, 4'hF);
	// Port 1 seen from I
	set_row(6, `OCP_CMD_READ, 32'h8000_0104, '0, 4'hF, `OCP_CMD_IDLE, '0, '0, '0);
	set_row(7, `OCP_CMD_WRITE, 32'h8000_0200, 32'h0BAD_F00D, 4'hF, `OCP_CMD_IDLE, '0, '0, '0);
	// Same port conflicts where D goes first
	set_row(8, `OCP_CMD_READ, 32'h0000_0010, '0, 4'hF, `OCP_CMD_READ, 32'h0000_0020, '0, 4'hF);
	set_row(9, `OCP_CMD_READ, 32'h8000_0200, '0, 4'hF,
		`OCP_CMD_WRITE, 32'h8000_0208, 32'hAABB_CCDD, 4'b0101);
	// Different ports at the same time
	set_row(10, `OCP_CMD_READ, 32'h8000_0208, '0, 4'hF, `OCP_CMD_READ, 32'h0000_0010, '0, 4'hF);
	set_row(11, `OCP_CMD_READ, 32'h0000_0020, '0, 4'hF,
		`OCP_CMD_WRITE, 32'h8000_0104, 32'h5566_7788, 4'b1001);
	set_row(12, `OCP_CMD_IDLE, '0, '0, '0, `OCP_CMD_READ, 32'h8000_0104, '0, 4'hF);
	set_row(13, `OCP_CMD_READ, 32'h0000_0020, '0, 4'hF, `OCP_CMD_IDLE, '0, '0, '0);

	// Expected read data, with D ahead of I as the arbitration orders them
	for (int r = 0; r < NUM_ROWS; r++)
	begin
		ref_access(tab_dcmd[r], tab_daddr[r], tab_ddata[r], tab_dben[r], rd);
		exp_ddata[r] = rd;
		ref_access(tab_icmd[r], tab_iaddr[r], tab_idata[r], tab_iben[r], rd);
		exp_idata[r] = rd;
	end

	@(posedge nrst);
	@(negedge clk);
	check_value("o_p0_mcmd", p_cmd[0], `OCP_CMD_IDLE);	// Quiet bus after reset
	check_value("o_p1_mcmd", p_cmd[1], `OCP_CMD_IDLE);
	check_value("o_i_sresp", ibus_resp, `OCP_RESP_NULL);
	check_value("o_d_sresp", dbus_resp, `OCP_RESP_NULL);
	check_value("o_i_scmdaccept", ibus_accept, 1'b1);
	check_value("o_d_scmdaccept", dbus_accept, 1'b1);

	for (int r = 0; r < NUM_ROWS; r++)
		run_row(r);

	repeat (2) @(posedge clk);
	$display("Simulation passed");
	$finish;
end

endmodule

//--- testbench/tb_clock_gen.sv
// Free running clock and a power-on reset for the testbench
module tb_clock_gen #(
	parameter int HALF_PERIOD = 4,	// Period of 8 time units
	parameter int RESET_CYCLES = 16
)
(
	output logic	o_clk,
	output logic	o_nrst
);

initial
begin
	o_clk = 1'b0;
	forever
		#HALF_PERIOD o_clk = ~o_clk;
end

// Reset leaves on a falling edge so no flop sees it change with the clock
initial
begin
	o_nrst = 1'b0;
	repeat (RESET_CYCLES) @(posedge o_clk);
	@(negedge o_clk);
	o_nrst = 1'b1;
end

endmodule

//--- source/ocp_fabric.sv
`include "fabric_consts.svh"

// Two-master, two-port OCP fabric
module ocp_fabric
(
	input logic			clk,
	input logic			nrst,
	// Instruction master
	input fabric_pkg::addr_t	i_i_maddr,
	input fabric_pkg::cmd_t		i_i_mcmd,
	input fabric_pkg::data_t	i_i_mdata,
	input fabric_pkg::ben_t		i_i_mbyteen,
	output logic			o_i_scmdaccept,
	output fabric_pkg::data_t	o_i_sdata,
	output fabric_pkg::resp_t	o_i_sresp,
	// Data master
	input fabric_pkg::addr_t	i_d_maddr,
	input fabric_pkg::cmd_t		i_d_mcmd,
	input fabric_pkg::data_t	i_d_mdata,
	input fabric_pkg::ben_t		i_d_mbyteen,
	output logic			o_d_scmdaccept,
	output fabric_pkg::data_t	o_d_sdata,
	output fabric_pkg::resp_t	o_d_sresp,
	// Slave port 0
	output fabric_pkg::addr_t	o_p0_maddr,
	output fabric_pkg::cmd_t	o_p0_mcmd,
	output fabric_pkg::data_t	o_p0_mdata,
	output fabric_pkg::ben_t	o_p0_mbyteen,
	input logic			i_p0_scmdaccept,
	input fabric_pkg::data_t	i_p0_sdata,
	input fabric_pkg::resp_t	i_p0_sresp,
	// Slave port 1
	output fabric_pkg::addr_t	o_p1_maddr,
	output fabric_pkg::cmd_t	o_p1_mcmd,
	output fabric_pkg::data_t	o_p1_mdata,
	output fabric_pkg::ben_t	o_p1_mbyteen,
	input logic			i_p1_scmdaccept,
	input fabric_pkg::data_t	i_p1_sdata,
	input fabric_pkg::resp_t	i_p1_sresp
);

ocp_if u_ibus ();	// Instruction master as a bundle
ocp_if u_dbus ();	// Data master as a bundle
ocp_if u_iport [`NUM_PORTS] ();	// I commands into each port and their returns
ocp_if u_dport [`NUM_PORTS] ();	// D commands into each port and their returns
ocp_if u_pbus [`NUM_PORTS] ();	// Slave side of each port

// *************************************************************************
// Master side
// *************************************************************************

assign u_ibus.MAddr = i_i_maddr;
assign u_ibus.MCmd = i_i_mcmd;
assign u_ibus.MData = i_i_mdata;
assign u_ibus.MByteEn = i_i_mbyteen;
assign o_i_scmdaccept = u_ibus.SCmdAccept;
assign o_i_sdata = u_ibus.SData;
assign o_i_sresp = u_ibus.SResp;

assign u_dbus.MAddr = i_d_maddr;
assign u_dbus.MCmd = i_d_mcmd;
assign u_dbus.MData = i_d_mdata;
assign u_dbus.MByteEn = i_d_mbyteen;
assign o_d_scmdaccept = u_dbus.SCmdAccept;
assign o_d_sdata = u_dbus.SData;
assign o_d_sresp = u_dbus.SResp;

// *************************************************************************
// Ports
// *************************************************************************

genvar gp;
generate
	for (gp = 0; gp < `NUM_PORTS; gp++)
	begin : g_port
		// Every port sees both masters and claims what it decodes as its own
		assign u_iport[gp].MAddr = u_ibus.MAddr;
		assign u_iport[gp].MCmd = u_ibus.MCmd;
		assign u_iport[gp].MData = u_ibus.MData;
		assign u_iport[gp].MByteEn = u_ibus.MByteEn;
		assign u_dport[gp].MAddr = u_dbus.MAddr;
		assign u_dport[gp].MCmd = u_dbus.MCmd;
		assign u_dport[gp].MData = u_dbus.MData;
		assign u_dport[gp].MByteEn = u_dbus.MByteEn;

		fabric_port #(
			.PORT	(fabric_pkg::port_no_t'(gp))
		) u_port (
			.clk	(clk),
			.nrst	(nrst),
			.i_ibus	(u_iport[gp]),
			.i_dbus	(u_dport[gp]),
			.o_pbus	(u_pbus[gp])
		);
	end
endgenerate

fabric_resp_join u_resp_join (
	.clk		(clk),
	.nrst		(nrst),
	.i_iport	(u_iport),
	.i_dport	(u_dport),
	.o_ibus		(u_ibus),
	.o_dbus		(u_dbus)
);

// *************************************************************************
// Slave side
// *************************************************************************

assign o_p0_maddr = u_pbus[0].MAddr;
assign o_p0_mcmd = u_pbus[0].MCmd;
assign o_p0_mdata = u_pbus[0].MData;
assign o_p0_mbyteen = u_pbus[0].MByteEn;
assign u_pbus[0].SCmdAccept = i_p0_scmdaccept;
assign u_pbus[0].SData = i_p0_sdata;
assign u_pbus[0].SResp = i_p0_sresp;

assign o_p1_maddr = u_pbus[1].MAddr;
assign o_p1_mcmd = u_pbus[1].MCmd;
assign o_p1_mdata = u_pbus[1].MData;
assign o_p1_mbyteen = u_pbus[1].MByteEn;
assign u_pbus[1].SCmdAccept = i_p1_scmdaccept;
assign u_pbus[1].SData = i_p1_sdata;
assign u_pbus[1].SResp = i_p1_sresp;

endmodule

//--- fabric/fabric_resp_join.sv
`include "fabric_consts.svh"

// Folds the returns of every port into one return per master
module fabric_resp_join
(
	input logic	clk,
	input logic	nrst,
	ocp_if.master	i_iport [`NUM_PORTS],	// Instruction returns of each port
	ocp_if.master	i_dport [`NUM_PORTS],	// Data returns of each port
	ocp_if.slave	o_ibus,	// Instruction master
	ocp_if.slave	o_dbus	// Data master
);

localparam int NUM_MASTERS = 2;	// Index 0 is I and index 1 is D

// Returns gathered as master by port
logic [`NUM_PORTS-1:0]	acc [NUM_MASTERS];
logic [`NUM_PORTS-1:0]	rvalid [NUM_MASTERS];	// Port answers in this cycle
fabric_pkg::data_t	data [NUM_MASTERS][`NUM_PORTS];
fabric_pkg::resp_t	resp [NUM_MASTERS][`NUM_PORTS];

// Merged result per master
logic			macc [NUM_MASTERS];
fabric_pkg::data_t	mdata [NUM_MASTERS];
fabric_pkg::resp_t	mresp [NUM_MASTERS];

genvar gp;
generate
	for (gp = 0; gp < `NUM_PORTS; gp++)
	begin : g_port
		assign acc[0][gp] = i_iport[gp].SCmdAccept;
		assign data[0][gp] = i_iport[gp].SData;
		assign resp[0][gp] = i_iport[gp].SResp;
		assign rvalid[0][gp] = (i_iport[gp].SResp != `OCP_RESP_NULL);
		assign acc[1][gp] = i_dport[gp].SCmdAccept;
		assign data[1][gp] = i_dport[gp].SData;
		assign resp[1][gp] = i_dport[gp].SResp;
		assign rvalid[1][gp] = (i_dport[gp].SResp != `OCP_RESP_NULL);
	end
endgenerate

// Ports a master does not address report accept, so the AND is safe
always_comb
begin
	for (int m = 0; m < NUM_MASTERS; m++)
	begin
		macc[m] = &acc[m];
		mresp[m] = `OCP_RESP_NULL;
		mdata[m] = '0;
		for (int q = 0; q < `NUM_PORTS; q++)
		begin
			if (rvalid[m][q])
			begin
				mresp[m] = resp[m][q];	// Only the answering port counts
				mdata[m] = data[m][q];
			end
		end
	end
end

assign o_ibus.SCmdAccept = macc[0];
assign o_ibus.SData = mdata[0];
assign o_ibus.SResp = mresp[0];
assign o_dbus.SCmdAccept = macc[1];
assign o_dbus.SData = mdata[1];
assign o_dbus.SResp = mresp[1];

// A master has one transaction open, so one port at most can answer it
a_i_one_resp: assert property (@(posedge clk) disable iff (!nrst) $onehot0(rvalid[0]));
a_d_one_resp: assert property (@(posedge clk) disable iff (!nrst) $onehot0(rvalid[1]));

endmodule

//--- fabric/fabric_port.sv
`include "fabric_consts.svh"

// One slave port of the fabric with its own I and D request FSMs
module fabric_port #(
	parameter fabric_pkg::port_no_t PORT = '0	// Port number this instance answers to
)
(
	input logic	clk,
	input logic	nrst,
	ocp_if.slave	i_ibus,	// Instruction master as the port sees it
	ocp_if.slave	i_dbus,	// Data master as the port sees it
	ocp_if.master	o_pbus	// Toward the slave on this port
);

// *************************************************************************
// Address helpers
// *************************************************************************

// Port 0 for a clear bit 31, otherwise bits 30..20 plus one
function automatic fabric_pkg::port_no_t port_no(input fabric_pkg::addr_t addr);
	if (addr[`ADDR_WIDTH-1])
		return addr[`ADDR_WIDTH-2:`ADDR_WIDTH-`PORT_BITS] + 1'b1;
	return '0;
endfunction

// The slave only sees the low 20 bits behind a port above 0
function automatic fabric_pkg::addr_t decode_addr(input fabric_pkg::addr_t addr);
	if (addr[`ADDR_WIDTH-1])
		return {{`PORT_BITS{1'b0}}, addr[`ADDR_WIDTH-`PORT_BITS-1:0]};
	return addr;
endfunction

// Two live commands that aim at the same port
function automatic logic confl(
	input fabric_pkg::addr_t	a_addr,
	input fabric_pkg::cmd_t		a_cmd,
	input fabric_pkg::addr_t	b_addr,
	input fabric_pkg::cmd_t		b_cmd
);
	return (a_cmd != `OCP_CMD_IDLE) && (b_cmd != `OCP_CMD_IDLE) &&
		(port_no(a_addr) == port_no(b_addr));
endfunction

// *************************************************************************
// State and request storage
// *************************************************************************

fabric_pkg::bus_state_t	i_state;	// Instruction side FSM
fabric_pkg::bus_state_t	d_state;	// Data side FSM

logic	i_busy;	// Instruction transaction in flight on this port
logic	d_busy;	// Data transaction in flight on this port
logic	sel_i;	// Port owner for the demux

// Commands parked in BUS_CONF
fabric_pkg::addr_t	i_pend_addr;
fabric_pkg::cmd_t	i_pend_cmd;
fabric_pkg::data_t	i_pend_data;
fabric_pkg::ben_t	i_pend_ben;
fabric_pkg::addr_t	d_pend_addr;
fabric_pkg::cmd_t	d_pend_cmd;
fabric_pkg::data_t	d_pend_data;
fabric_pkg::ben_t	d_pend_ben;

// FSM decisions for this cycle
logic	i_hit;	// I master addresses this port
logic	i_park;	// Take the I command but hold it back
logic	i_go_new;	// Issue the I command straight from the master
logic	i_go_pend;	// Issue the parked I command
logic	d_hit;
logic	d_park;
logic	d_go_new;
logic	d_go_pend;

// Latched commands on their way to the demux
ocp_if u_icmd ();
ocp_if u_dcmd ();

assign i_busy = (i_state == fabric_pkg::BUS_WAIT);
assign d_busy = (d_state == fabric_pkg::BUS_WAIT);
assign sel_i = !d_busy;	// I owns the port unless D is in flight

// *************************************************************************
// Arbitration
// *************************************************************************

assign i_hit = (i_ibus.MCmd != `OCP_CMD_IDLE) && (port_no(i_ibus.MAddr) == PORT);
assign d_hit = (i_dbus.MCmd != `OCP_CMD_IDLE) && (port_no(i_dbus.MAddr) == PORT);

// I gives way to a D command in the same cycle, to D in flight and to a parked D
assign i_park = (i_state == fabric_pkg::BUS_IDLE) && i_hit &&
	(confl(i_ibus.MAddr, i_ibus.MCmd, i_dbus.MAddr, i_dbus.MCmd) || d_busy ||
	(d_state == fabric_pkg::BUS_CONF));
assign i_go_new = (i_state == fabric_pkg::BUS_IDLE) && i_hit && !i_park;
assign i_go_pend = (i_state == fabric_pkg::BUS_CONF) && !d_busy &&
	!confl(i_pend_addr, i_pend_cmd, i_dbus.MAddr, i_dbus.MCmd);

// D only waits while I holds the port
assign d_park = (d_state == fabric_pkg::BUS_IDLE) && d_hit && i_busy;
assign d_go_new = (d_state == fabric_pkg::BUS_IDLE) && d_hit && !i_busy;
assign d_go_pend = (d_state == fabric_pkg::BUS_CONF) && !i_busy;

// Masters see a combinational accept from the FSM state
assign i_ibus.SCmdAccept = (i_state == fabric_pkg::BUS_IDLE) || (i_ibus.MCmd == `OCP_CMD_IDLE);
assign i_dbus.SCmdAccept = (d_state == fabric_pkg::BUS_IDLE) || (i_dbus.MCmd == `OCP_CMD_IDLE);

// Responses come back through the demux in the same cycle
assign i_ibus.SData = u_icmd.SData;
assign i_ibus.SResp = u_icmd.SResp;
assign i_dbus.SData = u_dcmd.SData;
assign i_dbus.SResp = u_dcmd.SResp;

// *************************************************************************
// Instruction side FSM
// *************************************************************************

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		i_state <= fabric_pkg::BUS_IDLE;
		u_icmd.MCmd <= `OCP_CMD_IDLE;
	end
	else
	begin
		case (i_state)
		fabric_pkg::BUS_IDLE:
		begin
			if (i_park)
				i_state <= fabric_pkg::BUS_CONF;
			else if (i_go_new)
			begin
				u_icmd.MCmd <= i_ibus.MCmd;	// Appears on the port one cycle after capture
				i_state <= fabric_pkg::BUS_WAIT;
			end
		end
		fabric_pkg::BUS_CONF:
		begin
			if (i_go_pend)
			begin
				u_icmd.MCmd <= i_pend_cmd;
				i_state <= fabric_pkg::BUS_WAIT;
			end
		end
		fabric_pkg::BUS_WAIT:
		begin
			if (u_icmd.SCmdAccept)
				u_icmd.MCmd <= `OCP_CMD_IDLE;	// Slave has taken it
			if (u_icmd.SResp != `OCP_RESP_NULL)
				i_state <= fabric_pkg::BUS_IDLE;	// Response cycle ends the transaction
		end
		default:
			i_state <= fabric_pkg::BUS_IDLE;
		endcase
	end
end

// Payload follows the same decisions
always_ff @(posedge clk)
begin
	if (i_park)
	begin
		i_pend_addr <= i_ibus.MAddr;
		i_pend_cmd <= i_ibus.MCmd;
		i_pend_data <= i_ibus.MData;
		i_pend_ben <= i_ibus.MByteEn;
	end
	if (i_go_new)
	begin
		u_icmd.MAddr <= decode_addr(i_ibus.MAddr);
		u_icmd.MData <= i_ibus.MData;
		u_icmd.MByteEn <= i_ibus.MByteEn;
	end
	else if (i_go_pend)
	begin
		u_icmd.MAddr <= decode_addr(i_pend_addr);
		u_icmd.MData <= i_pend_data;
		u_icmd.MByteEn <= i_pend_ben;
	end
end

// *************************************************************************
// Data side FSM
// *************************************************************************

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		d_state <= fabric_pkg::BUS_IDLE;
		u_dcmd.MCmd <= `OCP_CMD_IDLE;
	end
	else
	begin
		case (d_state)
		fabric_pkg::BUS_IDLE:
		begin
			if (d_park)
				d_state <= fabric_pkg::BUS_CONF;
			else if (d_go_new)
			begin
				u_dcmd.MCmd <= i_dbus.MCmd;
				d_state <= fabric_pkg::BUS_WAIT;
			end
		end
		fabric_pkg::BUS_CONF:
		begin
			if (d_go_pend)
			begin
				u_dcmd.MCmd <= d_pend_cmd;	// One cycle after the I response
				d_state <= fabric_pkg::BUS_WAIT;
			end
		end
		fabric_pkg::BUS_WAIT:
		begin
			if (u_dcmd.SCmdAccept)
				u_dcmd.MCmd <= `OCP_CMD_IDLE;
			if (u_dcmd.SResp != `OCP_RESP_NULL)
				d_state <= fabric_pkg::BUS_IDLE;
		end
		default:
			d_state <= fabric_pkg::BUS_IDLE;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (d_park)
	begin
		d_pend_addr <= i_dbus.MAddr;
		d_pend_cmd <= i_dbus.MCmd;
		d_pend_data <= i_dbus.MData;
		d_pend_ben <= i_dbus.MByteEn;
	end
	if (d_go_new)
	begin
		u_dcmd.MAddr <= decode_addr(i_dbus.MAddr);
		u_dcmd.MData <= i_dbus.MData;
		u_dcmd.MByteEn <= i_dbus.MByteEn;
	end
	else if (d_go_pend)
	begin
		u_dcmd.MAddr <= decode_addr(d_pend_addr);
		u_dcmd.MData <= d_pend_data;
		u_dcmd.MByteEn <= d_pend_ben;
	end
end

// Only the owner's command reaches the slave
fabric_port_demux u_demux (
	.i_select	(sel_i),
	.i_icmd		(u_icmd),
	.i_dcmd		(u_dcmd),
	.o_pbus		(o_pbus)
);

// The port never serves both masters at once
a_one_owner: assert property (@(posedge clk) disable iff (!nrst) !(i_busy && d_busy));

endmodule

//--- fabric/fabric_port_demux.sv
`include "fabric_consts.svh"

// Puts the owning master's latched command on the port and returns the
// slave's answer to that master alone
module fabric_port_demux
(
	input logic	i_select,	// High gives the port to I
	ocp_if.slave	i_icmd,	// Latched instruction command
	ocp_if.slave	i_dcmd,	// Latched data command
	ocp_if.master	o_pbus	// Slave port
);

// *************************************************************************
// Command path
// *************************************************************************

assign o_pbus.MAddr = i_select ? i_icmd.MAddr : i_dcmd.MAddr;
assign o_pbus.MCmd = i_select ? i_icmd.MCmd : i_dcmd.MCmd;
assign o_pbus.MData = i_select ? i_icmd.MData : i_dcmd.MData;
assign o_pbus.MByteEn = i_select ? i_icmd.MByteEn : i_dcmd.MByteEn;

// *************************************************************************
// Return path
// *************************************************************************

// The master that does not own the port sees no accept and no response
assign i_icmd.SCmdAccept = i_select & o_pbus.SCmdAccept;
assign i_icmd.SData = i_select ? o_pbus.SData : '0;
assign i_icmd.SResp = i_select ? o_pbus.SResp : `OCP_RESP_NULL;

assign i_dcmd.SCmdAccept = !i_select & o_pbus.SCmdAccept;
assign i_dcmd.SData = i_select ? '0 : o_pbus.SData;
assign i_dcmd.SResp = i_select ? `OCP_RESP_NULL : o_pbus.SResp;

endmodule

//--- common/ocp_if.sv
// OCP command and response bundle between one master and one slave
interface ocp_if;

	// Driven by the master
	fabric_pkg::addr_t	MAddr;	// Byte address of the command
	fabric_pkg::cmd_t	MCmd;	// Command is valid while this is not IDLE
	fabric_pkg::data_t	MData;	// Write data
	fabric_pkg::ben_t	MByteEn;	// Byte enables of the write

	// Driven by the slave
	logic			SCmdAccept;	// Command is taken on an edge where this is high
	fabric_pkg::data_t	SData;	// Read data, valid in the response cycle
	fabric_pkg::resp_t	SResp;	// A single DVA cycle ends the transaction

	// The side that issues commands
	modport master
	(
		output	MAddr,
		output	MCmd,
		output	MData,
		output	MByteEn,
		input	SCmdAccept,
		input	SData,
		input	SResp
	);

	// The side that answers them
	modport slave
	(
		input	MAddr,
		input	MCmd,
		input	MData,
		input	MByteEn,
		output	SCmdAccept,
		output	SData,
		output	SResp
	);

endinterface

//--- common/fabric_pkg.sv
`include "fabric_consts.svh"

// Types shared by the fabric modules and the OCP bundle
package fabric_pkg;

	// Payload carried by an OCP command
	typedef logic [`ADDR_WIDTH-1:0]	addr_t;	// Byte address
	typedef logic [`DATA_WIDTH-1:0]	data_t;	// Write or read data word
	typedef logic [`BEN_WIDTH-1:0]	ben_t;	// Byte enables

	// Control codes of the protocol
	typedef logic [2:0]	cmd_t;	// Holds the OCP_CMD_* codes
	typedef logic [1:0]	resp_t;	// Holds the OCP_RESP_* codes

	// Port number as decoded from bits 30..20 of an address
	typedef logic [`PORT_BITS-2:0]	port_no_t;

	// One-hot states of the per-master port FSMs
	typedef enum logic [2:0]
	{
		BUS_IDLE = 3'b001,	// Nothing in flight for this master
		BUS_WAIT = 3'b010,	// Command issued and waiting for the slave response
		BUS_CONF = 3'b100	// Command parked until the other master frees the port
	} bus_state_t;

endpackage

//--- common/fabric_consts.svh
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// *************************************************************************
// Bus widths
// *************************************************************************

`define ADDR_WIDTH	32	// Byte address width of both masters and ports
`define DATA_WIDTH	32	// One bus word per transfer
`define BEN_WIDTH	4	// One enable bit for each data byte

// Bit 31 plus the eleven bits that hold the port number minus one
`define PORT_BITS	12

`define NUM_PORTS	2	// Slave ports behind the fabric

// *************************************************************************
// OCP command and response codes
// *************************************************************************

`define OCP_CMD_IDLE	3'b000	// No command on the bus
`define OCP_CMD_WRITE	3'b001	// Write MData under MByteEn
`define OCP_CMD_READ	3'b010	// Read one word

`define OCP_RESP_NULL	2'b00	// No response in this cycle
`define OCP_RESP_DVA	2'b01	// Read data valid or write done

`endif
